// ==== logic/core_types_pkg.sv ====
// core type definitions
// widths shared across the out-of-order core, and the operand word that a
// reservation station slot reads either as a physical register tag or as a value

`default_nettype none

package core_types_pkg;

    localparam int xlen     = 32;  // data and address width
    localparam int preg_len = 6;   // physical register tag
    localparam int rob_len  = 5;   // reorder buffer index

    // one operand slot, holding a tag until its producer broadcasts
    typedef union packed {
        logic [xlen-1:0] as_value;
        struct packed {
            logic [xlen-preg_len-1:0] pad;  // kept zero while waiting
            logic [preg_len-1:0]      tag;
        } as_tag;
    } operand_word_t;

endpackage

`default_nettype wire

// ==== logic/rs_branch_pkg.sv ====
// branch reservation station definitions
// station size, entry index width and the branch comparison codes

`default_nettype none

package rs_branch_pkg;

    localparam int rs_br_size  = 4;  // number of entries
    localparam int rs_br_len   = 2;  // entry index width
    localparam int br_func_len = 3;

    //////////////////////////////////////////////////
    // comparison codes follow the funct3 field
    //////////////////////////////////////////////////

    localparam logic [br_func_len-1:0] br_beq  = 3'b000;
    localparam logic [br_func_len-1:0] br_bne  = 3'b001;
    localparam logic [br_func_len-1:0] br_blt  = 3'b100;
    localparam logic [br_func_len-1:0] br_bge  = 3'b101;
    localparam logic [br_func_len-1:0] br_bltu = 3'b110;
    localparam logic [br_func_len-1:0] br_bgeu = 3'b111;

endpackage

`default_nettype wire

// ==== logic/rs_dispatch_alloc.sv ====
// branch station allocator
// steers a dispatch to the lowest free entry and tracks occupancy

`timescale 1ns/1ps
`default_nettype none

module rs_dispatch_alloc
    import rs_branch_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  enable,
    input  logic [rs_br_size-1:0] busy,
    input  logic                  issue_fire,
    output logic [rs_br_size-1:0] alloc,
    output logic                  rs_branch_full
);

    logic [rs_br_len:0]    count;
    logic [rs_br_size-1:0] free_lowest;
    logic                  accept;

    // isolate the lowest zero bit of busy
    assign free_lowest    = ~busy & (busy + 1'b1);
    assign rs_branch_full = (count == rs_br_size);
    assign accept         = enable && !rs_branch_full;  // dropped when full
    assign alloc          = accept ? free_lowest : '0;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            count <= '0;
        end else if (accept && !issue_fire) begin
            count <= count + 1'b1;
        end else if (!accept && issue_fire) begin
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rs_branch_entry.sv ====
// branch station entry
// holds one waiting branch or jump, snoops the common data bus for its
// pending operands and requests issue once both are present

`timescale 1ns/1ps
`default_nettype none

module rs_branch_entry
    import core_types_pkg::*, rs_branch_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   alloc,
    input  logic                   release_slot,  // granted this cycle
    // dispatch fields
    input  logic [xlen-1:0]        pc,
    input  logic [xlen-1:0]        npc,
    input  logic [xlen-1:0]        offset,
    input  logic                   opa_ready,
    input  logic [xlen-1:0]        opa_value,
    input  logic [preg_len-1:0]    opa_preg_idx,
    input  logic                   opb_ready,
    input  logic [xlen-1:0]        opb_value,
    input  logic [preg_len-1:0]    opb_preg_idx,
    input  logic                   is_jalr,
    input  logic [rob_len-1:0]     rob_idx,
    input  logic [preg_len-1:0]    dest_preg_idx,
    input  logic [br_func_len-1:0] branch_func,
    input  logic                   cond_branch,
    input  logic                   uncond_branch,
    input  logic                   br_pred_direction,
    input  logic [xlen-1:0]        br_pred_target_pc,
    // broadcast
    input  logic                   cdb_broadcast_valid,
    input  logic [preg_len-1:0]    cdb_dest_preg_idx,
    input  logic [xlen-1:0]        cdb_value,
    output logic                   busy,
    output logic                   ready,
    // stored fields
    output logic [xlen-1:0]        held_pc,
    output logic [xlen-1:0]        held_npc,
    output logic [xlen-1:0]        held_offset,
    output operand_word_t          held_opa,
    output operand_word_t          held_opb,
    output logic                   held_is_jalr,
    output logic [rob_len-1:0]     held_rob_idx,
    output logic [preg_len-1:0]    held_dest_preg_idx,
    output logic [br_func_len-1:0] held_branch_func,
    output logic                   held_cond_branch,
    output logic                   held_uncond_branch,
    output logic                   held_br_pred_direction,
    output logic [xlen-1:0]        held_br_pred_target_pc
);

    logic opa_ok;
    logic opb_ok;
    logic opa_hit;
    logic opb_hit;

    // tag match on a still pending operand
    assign opa_hit = cdb_broadcast_valid && busy && !opa_ok
                     && (held_opa.as_tag.tag == cdb_dest_preg_idx);
    assign opb_hit = cdb_broadcast_valid && busy && !opb_ok
                     && (held_opb.as_tag.tag == cdb_dest_preg_idx);
    assign ready   = busy && opa_ok && opb_ok;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            busy   <= 1'b0;
            opa_ok <= 1'b0;
            opb_ok <= 1'b0;
        end else if (alloc) begin
            busy   <= 1'b1;
            opa_ok <= opa_ready;
            opb_ok <= opb_ready;
        end else begin
            if (release_slot) busy <= 1'b0;
            if (opa_hit) opa_ok <= 1'b1;  // woken by broadcast
            if (opb_hit) opb_ok <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // payload capture and operand wakeup
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (alloc) begin
            held_pc                <= pc;
            held_npc               <= npc;
            held_offset            <= offset;
            held_is_jalr           <= is_jalr;
            held_rob_idx           <= rob_idx;
            held_dest_preg_idx     <= dest_preg_idx;
            held_branch_func       <= branch_func;
            held_cond_branch       <= cond_branch;
            held_uncond_branch     <= uncond_branch;
            held_br_pred_direction <= br_pred_direction;
            held_br_pred_target_pc <= br_pred_target_pc;
            if (opa_ready) begin
                held_opa.as_value <= opa_value;
            end else begin
                held_opa.as_tag.pad <= '0;
                held_opa.as_tag.tag <= opa_preg_idx;
            end
            if (opb_ready) begin
                held_opb.as_value <= opb_value;
            end else begin
                held_opb.as_tag.pad <= '0;
                held_opb.as_tag.tag <= opb_preg_idx;
            end
        end else begin
            if (opa_hit) held_opa.as_value <= cdb_value;
            if (opb_hit) held_opb.as_value <= cdb_value;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rs_issue_select.sv ====
// branch station issue selector
// grants the lowest ready entry each cycle and registers its fields
// toward the branch execute stage

`timescale 1ns/1ps
`default_nettype none

module rs_issue_select
    import core_types_pkg::*, rs_branch_pkg::*;
(
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              flush,
    input  logic [rs_br_size-1:0]             ready,
    input  logic [rs_br_size*xlen-1:0]        pc_bus,
    input  logic [rs_br_size*xlen-1:0]        npc_bus,
    input  logic [rs_br_size*xlen-1:0]        offset_bus,
    input  logic [rs_br_size*xlen-1:0]        opa_bus,
    input  logic [rs_br_size*xlen-1:0]        opb_bus,
    input  logic [rs_br_size-1:0]             is_jalr_bus,
    input  logic [rs_br_size*rob_len-1:0]     rob_idx_bus,
    input  logic [rs_br_size*preg_len-1:0]    dest_preg_bus,
    input  logic [rs_br_size*br_func_len-1:0] func_bus,
    input  logic [rs_br_size-1:0]             cond_bus,
    input  logic [rs_br_size-1:0]             uncond_bus,
    input  logic [rs_br_size-1:0]             pred_dir_bus,
    input  logic [rs_br_size*xlen-1:0]        pred_target_bus,
    output logic [rs_br_size-1:0]             grant,
    output logic                              issue_fire,
    output logic                              rs_branch_out_valid,
    output logic [xlen-1:0]                   out_pc,
    output logic [xlen-1:0]                   out_npc,
    output logic [xlen-1:0]                   out_offset,
    output logic [xlen-1:0]                   out_opa_value,
    output logic [xlen-1:0]                   out_opb_value,
    output logic                              out_is_jalr,
    output logic [rob_len-1:0]                out_rob_idx,
    output logic [preg_len-1:0]               out_dest_preg_idx,
    output logic [br_func_len-1:0]            out_branch_func,
    output logic                              out_cond_branch,
    output logic                              out_uncond_branch,
    output logic                              out_br_pred_direction,
    output logic [xlen-1:0]                   out_br_pred_target_pc
);

    logic [rs_br_len-1:0] pick;

    assign grant      = ready & (~ready + 1'b1);  // lowest index wins
    assign issue_fire = |ready;

    always_comb begin
        pick = '0;
        for (int i = 0; i < rs_br_size; i++) begin
            if (grant[i]) pick = rs_br_len'(i);
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            rs_branch_out_valid <= 1'b0;
        end else begin
            rs_branch_out_valid <= issue_fire;  // one cycle per grant
        end
    end

    always_ff @(posedge clock) begin
        if (issue_fire) begin
            out_pc                <= pc_bus[pick*xlen +: xlen];
            out_npc               <= npc_bus[pick*xlen +: xlen];
            out_offset            <= offset_bus[pick*xlen +: xlen];
            out_opa_value         <= opa_bus[pick*xlen +: xlen];
            out_opb_value         <= opb_bus[pick*xlen +: xlen];
            out_is_jalr           <= is_jalr_bus[pick];
            out_rob_idx           <= rob_idx_bus[pick*rob_len +: rob_len];
            out_dest_preg_idx     <= dest_preg_bus[pick*preg_len +: preg_len];
            out_branch_func       <= func_bus[pick*br_func_len +: br_func_len];
            out_cond_branch       <= cond_bus[pick];
            out_uncond_branch     <= uncond_bus[pick];
            out_br_pred_direction <= pred_dir_bus[pick];
            out_br_pred_target_pc <= pred_target_bus[pick*xlen +: xlen];
        end
    end

endmodule

`default_nettype wire

// ==== logic/rs_branch.sv ====
// branch reservation station
// four entries fed by the dispatch allocator and drained one per cycle
// by the issue selector; a misprediction flush empties the station

`timescale 1ns/1ps
`default_nettype none

module rs_branch
    import core_types_pkg::*, rs_branch_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   enable,
    input  logic [xlen-1:0]        pc,
    input  logic [xlen-1:0]        npc,
    input  logic [xlen-1:0]        offset,
    input  logic                   opa_ready,
    input  logic [xlen-1:0]        opa_value,
    input  logic [preg_len-1:0]    opa_preg_idx,
    input  logic                   opb_ready,
    input  logic [xlen-1:0]        opb_value,
    input  logic [preg_len-1:0]    opb_preg_idx,
    input  logic                   is_jalr,
    input  logic [rob_len-1:0]     rob_idx,
    input  logic [preg_len-1:0]    dest_preg_idx,
    input  logic [br_func_len-1:0] branch_func,
    input  logic                   cond_branch,
    input  logic                   uncond_branch,
    input  logic                   br_pred_direction,
    input  logic [xlen-1:0]        br_pred_target_pc,
    input  logic                   cdb_broadcast_valid,
    input  logic [preg_len-1:0]    cdb_dest_preg_idx,
    input  logic [xlen-1:0]        cdb_value,
    input  logic                   commit_mis_pred,
    output logic                   rs_branch_full,
    output logic                   rs_branch_out_valid,
    output logic [xlen-1:0]        out_pc,
    output logic [xlen-1:0]        out_npc,
    output logic [xlen-1:0]        out_offset,
    output logic [xlen-1:0]        out_opa_value,
    output logic [xlen-1:0]        out_opb_value,
    output logic                   out_is_jalr,
    output logic [rob_len-1:0]     out_rob_idx,
    output logic [preg_len-1:0]    out_dest_preg_idx,
    output logic [br_func_len-1:0] out_branch_func,
    output logic                   out_cond_branch,
    output logic                   out_uncond_branch,
    output logic                   out_br_pred_direction,
    output logic [xlen-1:0]        out_br_pred_target_pc
);

    logic [rs_br_size-1:0]             alloc;
    logic [rs_br_size-1:0]             busy;
    logic [rs_br_size-1:0]             ready;
    logic [rs_br_size-1:0]             grant;
    logic                              issue_fire;
    logic [rs_br_size*xlen-1:0]        pc_bus;
    logic [rs_br_size*xlen-1:0]        npc_bus;
    logic [rs_br_size*xlen-1:0]        offset_bus;
    operand_word_t [rs_br_size-1:0]    opa_bus;
    operand_word_t [rs_br_size-1:0]    opb_bus;
    logic [rs_br_size-1:0]             is_jalr_bus;
    logic [rs_br_size*rob_len-1:0]     rob_idx_bus;
    logic [rs_br_size*preg_len-1:0]    dest_preg_bus;
    logic [rs_br_size*br_func_len-1:0] func_bus;
    logic [rs_br_size-1:0]             cond_bus;
    logic [rs_br_size-1:0]             uncond_bus;
    logic [rs_br_size-1:0]             pred_dir_bus;
    logic [rs_br_size*xlen-1:0]        pred_target_bus;

    rs_dispatch_alloc alloc_i (
        .clock(clock), .reset(reset), .flush(commit_mis_pred),
        .enable(enable), .busy(busy), .issue_fire(issue_fire),
        .alloc(alloc), .rs_branch_full(rs_branch_full)
    );

    //////////////////////////////////////////////////
    // entries
    //////////////////////////////////////////////////

    for (genvar i = 0; i < rs_br_size; i++) begin : entry_g
        rs_branch_entry entry_i (
            .clock(clock), .reset(reset), .flush(commit_mis_pred),
            .alloc(alloc[i]), .release_slot(grant[i]),
            .pc(pc), .npc(npc), .offset(offset),
            .opa_ready(opa_ready), .opa_value(opa_value), .opa_preg_idx(opa_preg_idx),
            .opb_ready(opb_ready), .opb_value(opb_value), .opb_preg_idx(opb_preg_idx),
            .is_jalr(is_jalr), .rob_idx(rob_idx), .dest_preg_idx(dest_preg_idx),
            .branch_func(branch_func), .cond_branch(cond_branch),
            .uncond_branch(uncond_branch), .br_pred_direction(br_pred_direction),
            .br_pred_target_pc(br_pred_target_pc),
            .cdb_broadcast_valid(cdb_broadcast_valid),
            .cdb_dest_preg_idx(cdb_dest_preg_idx), .cdb_value(cdb_value),
            .busy(busy[i]), .ready(ready[i]),
            .held_pc(pc_bus[i*xlen +: xlen]),
            .held_npc(npc_bus[i*xlen +: xlen]),
            .held_offset(offset_bus[i*xlen +: xlen]),
            .held_opa(opa_bus[i]), .held_opb(opb_bus[i]),
            .held_is_jalr(is_jalr_bus[i]),
            .held_rob_idx(rob_idx_bus[i*rob_len +: rob_len]),
            .held_dest_preg_idx(dest_preg_bus[i*preg_len +: preg_len]),
            .held_branch_func(func_bus[i*br_func_len +: br_func_len]),
            .held_cond_branch(cond_bus[i]), .held_uncond_branch(uncond_bus[i]),
            .held_br_pred_direction(pred_dir_bus[i]),
            .held_br_pred_target_pc(pred_target_bus[i*xlen +: xlen])
        );
    end

    rs_issue_select select_i (
        .clock(clock), .reset(reset), .flush(commit_mis_pred),
        .ready(ready), .pc_bus(pc_bus), .npc_bus(npc_bus), .offset_bus(offset_bus),
        .opa_bus(opa_bus), .opb_bus(opb_bus), .is_jalr_bus(is_jalr_bus),
        .rob_idx_bus(rob_idx_bus), .dest_preg_bus(dest_preg_bus), .func_bus(func_bus),
        .cond_bus(cond_bus), .uncond_bus(uncond_bus), .pred_dir_bus(pred_dir_bus),
        .pred_target_bus(pred_target_bus),
        .grant(grant), .issue_fire(issue_fire),
        .rs_branch_out_valid(rs_branch_out_valid),
        .out_pc(out_pc), .out_npc(out_npc), .out_offset(out_offset),
        .out_opa_value(out_opa_value), .out_opb_value(out_opb_value),
        .out_is_jalr(out_is_jalr), .out_rob_idx(out_rob_idx),
        .out_dest_preg_idx(out_dest_preg_idx), .out_branch_func(out_branch_func),
        .out_cond_branch(out_cond_branch), .out_uncond_branch(out_uncond_branch),
        .out_br_pred_direction(out_br_pred_direction),
        .out_br_pred_target_pc(out_br_pred_target_pc)
    );

endmodule

`default_nettype wire

// ==== tests/rs_branch_props.sv ====
// branch reservation station properties
// invariants on the allocator, the selector and the occupancy count,
// bound into the station top level

`timescale 1ns/1ps
`default_nettype none

module rs_branch_props
    import rs_branch_pkg::*;
(
    input logic                  clock,
    input logic                  reset,
    input logic [rs_br_size-1:0] alloc,
    input logic [rs_br_size-1:0] grant,
    input logic [rs_br_size-1:0] busy,
    input logic                  full,
    input logic [rs_br_len:0]    count
);

    alloc_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(alloc))
        else $error("alloc vector selects more than one entry");

    grant_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(grant))
        else $error("grant vector selects more than one entry");

    // count tracks the busy entries
    count_matches_busy: assert property (@(posedge clock) disable iff (reset)
        count == $countones(busy))
        else $error("occupancy count differs from the number of busy entries");

    no_alloc_when_full: assert property (@(posedge clock) disable iff (reset)
        full |-> (alloc == '0))
        else $error("entry allocated while the station is full");

endmodule

bind rs_branch rs_branch_props props_i (
    .clock(clock), .reset(reset), .alloc(alloc), .grant(grant), .busy(busy),
    .full(rs_branch_full), .count(alloc_i.count)
);

`default_nettype wire

// ==== tests/rs_branch_tb.sv ====
// branch reservation station testbench
// drives dispatch, broadcast and flush traffic into the station and checks
// every issued instruction against a slot model kept alongside the DUT

`timescale 1ns/1ps
`default_nettype none

module rs_branch_tb;
    import core_types_pkg::*, rs_branch_pkg::*;

    localparam int cycle_limit = 400;  // well above the length of the tests
    localparam logic [br_func_len-1:0] func_codes [6] =
        '{br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};

    logic                   clock;
    logic                   reset;
    logic                   enable;
    logic [xlen-1:0]        pc;
    logic [xlen-1:0]        npc;
    logic [xlen-1:0]        offset;
    logic                   opa_ready;
    logic [xlen-1:0]        opa_value;
    logic [preg_len-1:0]    opa_preg_idx;
    logic                   opb_ready;
    logic [xlen-1:0]        opb_value;
    logic [preg_len-1:0]    opb_preg_idx;
    logic                   is_jalr;
    logic [rob_len-1:0]     rob_idx;
    logic [preg_len-1:0]    dest_preg_idx;
    logic [br_func_len-1:0] branch_func;
    logic                   cond_branch;
    logic                   uncond_branch;
    logic                   br_pred_direction;
    logic [xlen-1:0]        br_pred_target_pc;
    logic                   cdb_broadcast_valid;
    logic [preg_len-1:0]    cdb_dest_preg_idx;
    logic [xlen-1:0]        cdb_value;
    logic                   commit_mis_pred;
    logic                   rs_branch_full;
    logic                   rs_branch_out_valid;
    logic [xlen-1:0]        out_pc;
    logic [xlen-1:0]        out_npc;
    logic [xlen-1:0]        out_offset;
    logic [xlen-1:0]        out_opa_value;
    logic [xlen-1:0]        out_opb_value;
    logic                   out_is_jalr;
    logic [rob_len-1:0]     out_rob_idx;
    logic [preg_len-1:0]    out_dest_preg_idx;
    logic [br_func_len-1:0] out_branch_func;
    logic                   out_cond_branch;
    logic                   out_uncond_branch;
    logic                   out_br_pred_direction;
    logic [xlen-1:0]        out_br_pred_target_pc;

    // slot model
    logic                   m_busy   [rs_br_size];
    logic                   m_a_ok   [rs_br_size];
    logic                   m_b_ok   [rs_br_size];
    logic [xlen-1:0]        m_a      [rs_br_size];  // tag in the low bits while waiting
    logic [xlen-1:0]        m_b      [rs_br_size];
    logic [xlen-1:0]        m_pc     [rs_br_size];
    logic [xlen-1:0]        m_npc    [rs_br_size];
    logic [xlen-1:0]        m_offset [rs_br_size];
    logic [xlen-1:0]        m_target [rs_br_size];
    logic                   m_jalr   [rs_br_size];
    logic                   m_cond   [rs_br_size];
    logic                   m_uncond [rs_br_size];
    logic                   m_dir    [rs_br_size];
    logic [rob_len-1:0]     m_rob    [rs_br_size];
    logic [preg_len-1:0]    m_dest   [rs_br_size];
    logic [br_func_len-1:0] m_func   [rs_br_size];

    logic        exp_valid;
    int          exp_slot;
    logic        checking   = 1'b0;
    logic [31:0] lfsr_state = 32'h2cc8cccf;
    int          checks     = 0;
    int          mismatches = 0;
    int          cycles;

    rs_branch dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int width);
        logic [31:0] bits;
        logic        feedback;
        bits = '0;
        for (int k = 0; k < width; k++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            bits       = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    function automatic logic station_busy();
        logic any;
        any = 1'b0;
        for (int i = 0; i < rs_br_size; i++) any |= m_busy[i];
        return any;
    endfunction

    task automatic check_value(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_outputs();
        int busy_count;
        busy_count = 0;
        for (int i = 0; i < rs_br_size; i++) busy_count += m_busy[i];
        check_value("rs_branch_full", busy_count == rs_br_size, rs_branch_full);
        check_value("rs_branch_out_valid", exp_valid, rs_branch_out_valid);
        if (exp_valid) begin
            check_value("out_pc", m_pc[exp_slot], out_pc);
            check_value("out_npc", m_npc[exp_slot], out_npc);
            check_value("out_offset", m_offset[exp_slot], out_offset);
            check_value("out_opa_value", m_a[exp_slot], out_opa_value);
            check_value("out_opb_value", m_b[exp_slot], out_opb_value);
            check_value("out_is_jalr", m_jalr[exp_slot], out_is_jalr);
            check_value("out_rob_idx", m_rob[exp_slot], out_rob_idx);
            check_value("out_dest_preg_idx", m_dest[exp_slot], out_dest_preg_idx);
            check_value("out_branch_func", m_func[exp_slot], out_branch_func);
            check_value("out_cond_branch", m_cond[exp_slot], out_cond_branch);
            check_value("out_uncond_branch", m_uncond[exp_slot], out_uncond_branch);
            check_value("out_br_pred_direction", m_dir[exp_slot], out_br_pred_direction);
            check_value("out_br_pred_target_pc", m_target[exp_slot], out_br_pred_target_pc);
        end
    endtask

    task automatic capture_dispatch(input int s);
        m_busy[s]   = 1'b1;
        m_a_ok[s]   = opa_ready;
        m_b_ok[s]   = opb_ready;
        m_a[s]      = opa_ready ? opa_value : xlen'(opa_preg_idx);
        m_b[s]      = opb_ready ? opb_value : xlen'(opb_preg_idx);
        m_pc[s]     = pc;
        m_npc[s]    = npc;
        m_offset[s] = offset;
        m_target[s] = br_pred_target_pc;
        m_jalr[s]   = is_jalr;
        m_cond[s]   = cond_branch;
        m_uncond[s] = uncond_branch;
        m_dir[s]    = br_pred_direction;
        m_rob[s]    = rob_idx;
        m_dest[s]   = dest_preg_idx;
        m_func[s]   = branch_func;
    endtask

    //////////////////////////////////////////////////
    // reference model stepped between clock edges
    //////////////////////////////////////////////////

    always @(negedge clock) begin : model_step
        int grant_slot;
        int free_slot;
        int busy_count;
        if (checking) check_outputs();
        grant_slot = -1;
        free_slot  = -1;
        busy_count = 0;
        for (int i = rs_br_size - 1; i >= 0; i--) begin
            if (m_busy[i] && m_a_ok[i] && m_b_ok[i]) grant_slot = i;  // lowest wins
            if (!m_busy[i]) free_slot = i;
            busy_count += m_busy[i];
        end
        if (reset || commit_mis_pred) begin
            for (int i = 0; i < rs_br_size; i++) m_busy[i] = 1'b0;
            exp_valid = 1'b0;
            checking  = 1'b1;
        end else begin
            exp_valid = (grant_slot >= 0);
            exp_slot  = grant_slot;
            for (int i = 0; i < rs_br_size; i++) begin
                if (cdb_broadcast_valid && m_busy[i] && !m_a_ok[i]
                    && m_a[i][preg_len-1:0] == cdb_dest_preg_idx) begin
                    m_a[i]    = cdb_value;
                    m_a_ok[i] = 1'b1;
                end
                if (cdb_broadcast_valid && m_busy[i] && !m_b_ok[i]
                    && m_b[i][preg_len-1:0] == cdb_dest_preg_idx) begin
                    m_b[i]    = cdb_value;
                    m_b_ok[i] = 1'b1;
                end
            end
            if (grant_slot >= 0) m_busy[grant_slot] = 1'b0;
            if (enable && busy_count < rs_br_size) capture_dispatch(free_slot);
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic dispatch(input logic a_rdy, input logic [preg_len-1:0] a_tag,
                            input logic b_rdy, input logic [preg_len-1:0] b_tag);
        enable            = 1'b1;
        pc                = rand_bits(32);
        npc               = pc + 32'd4;
        offset            = rand_bits(32);
        opa_ready         = a_rdy;
        opa_value         = rand_bits(32);
        opa_preg_idx      = a_tag;
        opb_ready         = b_rdy;
        opb_value         = rand_bits(32);
        opb_preg_idx      = b_tag;
        is_jalr           = 1'(rand_bits(1));
        rob_idx           = rob_len'(rand_bits(rob_len));
        dest_preg_idx     = preg_len'(rand_bits(preg_len));
        branch_func       = func_codes[rand_bits(3) % 6];
        cond_branch       = 1'(rand_bits(1));
        uncond_branch     = ~cond_branch;
        br_pred_direction = 1'(rand_bits(1));
        br_pred_target_pc = rand_bits(32);
        next_cycle();
        enable = 1'b0;
    endtask

    task automatic broadcast(input logic [preg_len-1:0] tag);
        cdb_broadcast_valid = 1'b1;
        cdb_dest_preg_idx   = tag;
        cdb_value           = rand_bits(32);
        next_cycle();
        cdb_broadcast_valid = 1'b0;
    endtask

    task automatic flush_station();
        commit_mis_pred = 1'b1;
        next_cycle();
        commit_mis_pred = 1'b0;
    endtask

    // run until nothing waits and nothing is on the output
    task automatic drain();
        do begin
            next_cycle();
        end while (rs_branch_out_valid || station_busy());
    endtask

    initial begin : stimulus
        logic                a_rdy;
        logic                b_rdy;
        logic [preg_len-1:0] a_tag;
        logic [preg_len-1:0] b_tag;
        reset               = 1'b1;
        enable              = 1'b0;
        pc                  = '0;
        npc                 = '0;
        offset              = '0;
        opa_ready           = 1'b0;
        opa_value           = '0;
        opa_preg_idx        = '0;
        opb_ready           = 1'b0;
        opb_value           = '0;
        opb_preg_idx        = '0;
        is_jalr             = 1'b0;
        rob_idx             = '0;
        dest_preg_idx       = '0;
        branch_func         = br_beq;
        cond_branch         = 1'b0;
        uncond_branch       = 1'b0;
        br_pred_direction   = 1'b0;
        br_pred_target_pc   = '0;
        cdb_broadcast_valid = 1'b0;
        cdb_dest_preg_idx   = '0;
        cdb_value           = '0;
        commit_mis_pred     = 1'b0;
        idle(4);
        reset = 1'b0;
        idle(5);  // quiet station after reset

        dispatch(1'b1, 6'd0, 1'b1, 6'd0);
        drain();

        // pending operand sees a wrong tag before the matching one
        dispatch(1'b0, 6'd5, 1'b1, 6'd0);
        idle(3);
        broadcast(6'd9);
        idle(2);
        broadcast(6'd5);
        drain();

        // fill up and dispatch once more while full
        for (int k = 0; k < rs_br_size; k++) dispatch(1'b1, 6'd0, 1'b0, 6'(10 + k));
        dispatch(1'b1, 6'd0, 1'b1, 6'd0);
        idle(2);
        for (int k = 0; k < rs_br_size; k++) broadcast(6'(10 + k));
        drain();

        // three entries woken by one broadcast
        dispatch(1'b0, 6'd20, 1'b0, 6'd20);
        dispatch(1'b1, 6'd0, 1'b0, 6'd20);
        dispatch(1'b0, 6'd20, 1'b1, 6'd0);
        broadcast(6'd20);
        drain();

        //////////////////////////////////////////////////
        // flush with waiting, in-flight and full states
        //////////////////////////////////////////////////
        dispatch(1'b0, 6'd30, 1'b1, 6'd0);
        dispatch(1'b1, 6'd0, 1'b0, 6'd31);
        flush_station();
        broadcast(6'd30);
        broadcast(6'd31);
        idle(3);
        dispatch(1'b1, 6'd0, 1'b1, 6'd0);
        flush_station();
        idle(2);
        dispatch(1'b1, 6'd0, 1'b1, 6'd0);
        idle(1);
        flush_station();
        idle(2);
        for (int k = 0; k < rs_br_size; k++) dispatch(1'b0, 6'd33, 1'b1, 6'd0);
        flush_station();
        broadcast(6'd33);
        idle(3);

        // random mix over a small tag set
        repeat (24) begin
            if (rand_bits(2) != 0) begin
                a_rdy = 1'(rand_bits(1));
                a_tag = 6'd40 + preg_len'(rand_bits(2));
                b_rdy = 1'(rand_bits(1));
                b_tag = 6'd40 + preg_len'(rand_bits(2));
                dispatch(a_rdy, a_tag, b_rdy, b_tag);
            end else begin
                broadcast(6'd40 + preg_len'(rand_bits(2)));
            end
        end
        for (int k = 0; k < 4; k++) broadcast(6'(40 + k));  // wake any leftovers
        drain();

        $display("checks: %0d, mismatches: %0d", checks, mismatches);
        if (mismatches == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/core_types_pkg.sv
logic/rs_branch_pkg.sv
logic/rs_dispatch_alloc.sv
logic/rs_branch_entry.sv
logic/rs_issue_select.sv
logic/rs_branch.sv
tests/rs_branch_props.sv
tests/rs_branch_tb.sv

// ==== Makefile ====
# Verilator build and run for the branch reservation station

TOP       ?= rs_branch_tb
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Test OK" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
